/* hdl/ex_pkg.sv */
package ex_pkg;

    // machine word width
    localparam int xlen = 32;

    // 3R major opcodes, bits 31..15
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;
    localparam logic [16:0] op_mul_w = 17'h00038;

    // 2RI12 major opcode, bits 31..22
    localparam logic [9:0] op_addi_w = 10'h00a;

    // instruction not exist
    localparam logic [5:0] ecode_ine = 6'h0d;

    // bit 6 is the exception flag, bits 5..0 the ecode
    typedef logic [6:0] exc_w;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_and,
        alu_or,
        alu_xor,
        alu_mul,
        alu_none
    } alu_op_e;

    // one instruction word, seen as either of the two supported formats
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
    } inst_word_u;

    // rd sits in the same place in both views
    // so either view may be used for it

endpackage

/* hdl/ex1_decode_alu.sv */
module ex1_decode_alu (
    input  logic [31:0]  inst0,
    input  logic [31:0]  inst1,
    input  logic [31:0]  pc0,
    input  logic [31:0]  pc1,
    input  logic [31:0]  src_a0,
    input  logic [31:0]  src_b0,
    input  logic [31:0]  src_a1,
    input  logic [31:0]  src_b1,
    output logic [31:0]  res0,
    output logic [31:0]  res1,
    output logic         lane_ok0,
    output logic         lane_ok1,
    output logic [4:0]   rd0,
    output logic [4:0]   rd1,
    output logic         is_mul0,
    output ex_pkg::exc_w d_exc,
    output logic [31:0]  d_badv
);
    import ex_pkg::*;

    inst_word_u  w0;
    inst_word_u  w1;
    alu_op_e     op0;
    alu_op_e     op1;
    logic [31:0] opnd_b0;
    logic [31:0] opnd_b1;

    function automatic logic is_imm(input inst_word_u w);
        return w.ri12.opcode == op_addi_w;
    endfunction

    // addi.w shares the adder with add.w
    function automatic alu_op_e decode_op(input inst_word_u w);
        alu_op_e op;
        op = alu_none;
        if (is_imm(w)) begin
            op = alu_add;
        end else begin
            case (w.r3.opcode)
                op_add_w: op = alu_add;
                op_sub_w: op = alu_sub;
                op_slt:   op = alu_slt;
                op_and:   op = alu_and;
                op_or:    op = alu_or;
                op_xor:   op = alu_xor;
                op_mul_w: op = alu_mul;
                default:  op = alu_none;
            endcase
        end
        return op;
    endfunction

    function automatic logic [31:0] alu(input alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
        logic [31:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_slt: r = {31'b0, $signed(a) < $signed(b)};
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            // mul.w result is finished in EX2
            default: r = '0;
        endcase
        return r;
    endfunction

    assign w0 = inst0;
    assign w1 = inst1;

    assign op0 = decode_op(w0);
    assign op1 = decode_op(w1);

    // sign-extended si12 replaces rk for addi.w
    assign opnd_b0 = is_imm(w0) ? {{20{w0.ri12.si12[11]}}, w0.ri12.si12} : src_b0;
    assign opnd_b1 = is_imm(w1) ? {{20{w1.ri12.si12[11]}}, w1.ri12.si12} : src_b1;

    assign res0 = alu(op0, src_a0, opnd_b0);
    assign res1 = alu(op1, src_a1, opnd_b1);

    assign rd0 = w0.r3.rd;
    assign rd1 = w1.r3.rd;

    // only lane 0 owns the multiplier
    assign lane_ok0 = op0 != alu_none;
    assign lane_ok1 = (op1 != alu_none) && (op1 != alu_mul);
    assign is_mul0  = op0 == alu_mul;

    // lane 0 reports first
    always_comb begin
        d_exc  = '0;
        d_badv = '0;
        if (!lane_ok0) begin
            d_exc  = {1'b1, ecode_ine};
            d_badv = pc0;
        end else if (!lane_ok1) begin
            d_exc  = {1'b1, ecode_ine};
            d_badv = pc1;
        end
    end

endmodule

/* hdl/mul_partial.sv */
module mul_partial (
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] pp_hh,
    output logic [31:0] pp_hl,
    output logic [31:0] pp_lh,
    output logic [31:0] pp_ll,
    output logic [31:0] mul_comp
);
    import ex_pkg::*;

    localparam int half = xlen / 2;

    // halves, zero-extended to a full word
    logic [xlen-1:0] a_hi;
    logic [xlen-1:0] a_lo;
    logic [xlen-1:0] b_hi;
    logic [xlen-1:0] b_lo;
    logic [xlen-1:0] corr_a;
    logic [xlen-1:0] corr_b;

    assign a_hi = {{half{1'b0}}, a[xlen-1:half]};
    assign a_lo = {{half{1'b0}}, a[half-1:0]};
    assign b_hi = {{half{1'b0}}, b[xlen-1:half]};
    assign b_lo = {{half{1'b0}}, b[half-1:0]};

    // unsigned 16x16 products, each fits in one word
    assign pp_hh = a_hi * b_hi;
    assign pp_hl = a_hi * b_lo;
    assign pp_lh = a_lo * b_hi;
    assign pp_ll = a_lo * b_lo;

    // signed operand = unsigned value minus sign * 2^32
    // so subtract b (resp. a) from the upper word when a (resp. b) is negative
    assign corr_a   = a[xlen-1] ? b : '0;
    assign corr_b   = b[xlen-1] ? a : '0;
    assign mul_comp = '0 - corr_a - corr_b;

    always_comb begin
        if (!$isunknown({a, b})) begin
            assert final (!$isunknown({pp_hh, pp_hl, pp_lh, pp_ll, mul_comp}))
                else $error("mul_partial: unknown partial product from known operands");
        end
    end

endmodule

/* hdl/ex1_ex2_reg.sv */
module ex1_ex2_reg (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  logic         in_valid,
    input  logic         out_allowin,
    input  logic [31:0]  res0,
    input  logic [31:0]  res1,
    input  logic         lane_ok0,
    input  logic         lane_ok1,
    input  logic [4:0]   rd0,
    input  logic [4:0]   rd1,
    input  logic         is_mul0,
    input  ex_pkg::exc_w d_exc,
    input  logic [31:0]  d_badv,
    input  logic [31:0]  pp_hh,
    input  logic [31:0]  pp_hl,
    input  logic [31:0]  pp_lh,
    input  logic [31:0]  pp_ll,
    input  logic [31:0]  mul_comp,
    input  logic [31:0]  pc0,
    input  logic [31:0]  pc1,
    input  ex_pkg::exc_w fe_exc,
    input  logic [31:0]  fe_badv,
    output logic         in_allowin,
    output logic         r_valid,
    output logic [31:0]  r_res0,
    output logic [31:0]  r_res1,
    output logic         r_lane_ok0,
    output logic         r_lane_ok1,
    output logic [4:0]   r_rd0,
    output logic [4:0]   r_rd1,
    output logic         r_is_mul0,
    output logic [31:0]  r_pp_hh,
    output logic [31:0]  r_pp_hl,
    output logic [31:0]  r_pp_lh,
    output logic [31:0]  r_pp_ll,
    output logic [31:0]  r_mul_comp,
    output logic [31:0]  r_pc0,
    output logic [31:0]  r_pc1,
    output ex_pkg::exc_w r_exc,
    output logic [31:0]  r_badv
);

    logic accept;
    logic squash;

    // EX2 finishes in one cycle, so back-pressure comes only from downstream
    assign in_allowin = out_allowin;
    assign accept     = in_valid && out_allowin;

    // flush, or the held pair leaves with nothing behind it
    assign squash = flush || (out_allowin && !in_valid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid    <= 1'b0;
            r_lane_ok0 <= 1'b0;
            r_lane_ok1 <= 1'b0;
            r_is_mul0  <= 1'b0;
            r_exc      <= '0;
        end else if (squash) begin
            r_valid    <= 1'b0;
            r_lane_ok0 <= 1'b0;
            r_lane_ok1 <= 1'b0;
            r_is_mul0  <= 1'b0;
            r_exc      <= '0;
        end else if (accept) begin
            r_valid    <= 1'b1;
            r_lane_ok0 <= lane_ok0;
            r_lane_ok1 <= lane_ok1;
            r_is_mul0  <= is_mul0;
            // front-end exception is older, keep its code
            r_exc      <= {fe_exc[6] | d_exc[6], fe_exc[6] ? fe_exc[5:0] : d_exc[5:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_res0     <= res0;
            r_res1     <= res1;
            r_rd0      <= rd0;
            r_rd1      <= rd1;
            r_pp_hh    <= pp_hh;
            r_pp_hl    <= pp_hl;
            r_pp_lh    <= pp_lh;
            r_pp_ll    <= pp_ll;
            r_mul_comp <= mul_comp;
            r_pc0      <= pc0;
            r_pc1      <= pc1;
            r_badv     <= fe_exc[6] ? fe_badv : d_badv;
        end
    end

    a_flush_kills: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !r_valid)
        else $error("ex1_ex2_reg: pair still valid after flush");

    a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
        !out_allowin |=> $stable(r_pc0))
        else $error("ex1_ex2_reg: r_pc0 changed under stall");

endmodule

/* hdl/ex2_result.sv */
module ex2_result (
    input  logic         r_valid,
    input  logic [31:0]  r_res0,
    input  logic [31:0]  r_res1,
    input  logic         r_is_mul0,
    input  logic         r_lane_ok0,
    input  logic         r_lane_ok1,
    input  logic [31:0]  r_pp_hh,
    input  logic [31:0]  r_pp_hl,
    input  logic [31:0]  r_pp_lh,
    input  logic [31:0]  r_pp_ll,
    input  logic [31:0]  r_mul_comp,
    input  ex_pkg::exc_w r_exc,
    output logic [31:0]  wdata0,
    output logic [31:0]  wdata1,
    output logic         wen0,
    output logic         wen1
);
    import ex_pkg::*;

    localparam int half = xlen / 2;

    logic [2*xlen-1:0] prod;
    logic              exc_any;

    // weights 2^0, 2^16, 2^16, 2^32
    // compensation lands on the upper word with hh
    assign prod = {{xlen{1'b0}}, r_pp_ll}
                + {{half{1'b0}}, r_pp_hl, {half{1'b0}}}
                + {{half{1'b0}}, r_pp_lh, {half{1'b0}}}
                + {r_pp_hh, {xlen{1'b0}}}
                + {r_mul_comp, {xlen{1'b0}}};

    // mul.w keeps the low word
    assign wdata0 = r_is_mul0 ? prod[xlen-1:0] : r_res0;
    assign wdata1 = r_res1;

    // any exception kills the whole pair
    assign exc_any = r_exc[6];

    assign wen0 = r_valid && r_lane_ok0 && !exc_any;
    assign wen1 = r_valid && r_lane_ok1 && !exc_any;

endmodule

/* hdl/ex_top.sv */
module ex_top (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  logic         in_valid,
    input  logic         out_allowin,
    input  logic [31:0]  pc0,
    input  logic [31:0]  pc1,
    input  logic [31:0]  inst0,
    input  logic [31:0]  inst1,
    input  logic [31:0]  src_a0,
    input  logic [31:0]  src_b0,
    input  logic [31:0]  src_a1,
    input  logic [31:0]  src_b1,
    input  ex_pkg::exc_w fe_exc,
    input  logic [31:0]  fe_badv,
    output logic         in_allowin,
    output logic         out_valid,
    output logic [31:0]  out_pc0,
    output logic [31:0]  out_pc1,
    output logic [4:0]   out_rd0,
    output logic [4:0]   out_rd1,
    output logic [31:0]  wdata0,
    output logic [31:0]  wdata1,
    output logic         wen0,
    output logic         wen1,
    output ex_pkg::exc_w exc,
    output logic [31:0]  badv
);
    import ex_pkg::*;

    // EX1 outputs
    logic [31:0] res0;
    logic [31:0] res1;
    logic        lane_ok0;
    logic        lane_ok1;
    logic [4:0]  rd0;
    logic [4:0]  rd1;
    logic        is_mul0;
    exc_w        d_exc;
    logic [31:0] d_badv;
    logic [31:0] pp_hh;
    logic [31:0] pp_hl;
    logic [31:0] pp_lh;
    logic [31:0] pp_ll;
    logic [31:0] mul_comp;

    // EX2 side of the register
    logic        r_valid;
    logic [31:0] r_res0;
    logic [31:0] r_res1;
    logic        r_lane_ok0;
    logic        r_lane_ok1;
    logic        r_is_mul0;
    logic [31:0] r_pp_hh;
    logic [31:0] r_pp_hl;
    logic [31:0] r_pp_lh;
    logic [31:0] r_pp_ll;
    logic [31:0] r_mul_comp;
    exc_w        r_exc;

    ex1_decode_alu ex1_decode_alu_i (
        .inst0(inst0), .inst1(inst1), .pc0(pc0), .pc1(pc1),
        .src_a0(src_a0), .src_b0(src_b0), .src_a1(src_a1), .src_b1(src_b1),
        .res0(res0), .res1(res1), .lane_ok0(lane_ok0), .lane_ok1(lane_ok1),
        .rd0(rd0), .rd1(rd1), .is_mul0(is_mul0), .d_exc(d_exc), .d_badv(d_badv)
    );

    // multiplier front works on lane 0 operands only
    mul_partial mul_partial_i (
        .a(src_a0), .b(src_b0),
        .pp_hh(pp_hh), .pp_hl(pp_hl), .pp_lh(pp_lh), .pp_ll(pp_ll),
        .mul_comp(mul_comp)
    );

    ex1_ex2_reg ex1_ex2_reg_i (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .in_valid(in_valid), .out_allowin(out_allowin),
        .res0(res0), .res1(res1), .lane_ok0(lane_ok0), .lane_ok1(lane_ok1),
        .rd0(rd0), .rd1(rd1), .is_mul0(is_mul0), .d_exc(d_exc), .d_badv(d_badv),
        .pp_hh(pp_hh), .pp_hl(pp_hl), .pp_lh(pp_lh), .pp_ll(pp_ll),
        .mul_comp(mul_comp), .pc0(pc0), .pc1(pc1),
        .fe_exc(fe_exc), .fe_badv(fe_badv),
        .in_allowin(in_allowin), .r_valid(r_valid),
        .r_res0(r_res0), .r_res1(r_res1),
        .r_lane_ok0(r_lane_ok0), .r_lane_ok1(r_lane_ok1),
        .r_rd0(out_rd0), .r_rd1(out_rd1), .r_is_mul0(r_is_mul0),
        .r_pp_hh(r_pp_hh), .r_pp_hl(r_pp_hl), .r_pp_lh(r_pp_lh), .r_pp_ll(r_pp_ll),
        .r_mul_comp(r_mul_comp), .r_pc0(out_pc0), .r_pc1(out_pc1),
        .r_exc(r_exc), .r_badv(badv)
    );

    ex2_result ex2_result_i (
        .r_valid(r_valid), .r_res0(r_res0), .r_res1(r_res1),
        .r_is_mul0(r_is_mul0), .r_lane_ok0(r_lane_ok0), .r_lane_ok1(r_lane_ok1),
        .r_pp_hh(r_pp_hh), .r_pp_hl(r_pp_hl), .r_pp_lh(r_pp_lh), .r_pp_ll(r_pp_ll),
        .r_mul_comp(r_mul_comp), .r_exc(r_exc),
        .wdata0(wdata0), .wdata1(wdata1), .wen0(wen0), .wen1(wen1)
    );

    assign out_valid = r_valid;
    assign exc       = r_exc;

endmodule

/* tb/ex_tb.sv */
module ex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ex_pkg::*;

    localparam int max_rows = 40;

    // one issue pair, its controls and the outputs expected after it
    typedef struct packed {
        logic        valid;
        logic        allowin;
        logic        flush;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] a0;
        logic [31:0] b0;
        logic [31:0] a1;
        logic [31:0] b1;
        logic [31:0] pc0;
        exc_w        fe_exc;
        logic [31:0] fe_badv;
        logic        e_valid;
        logic        e_allowin;
        logic        e_wen0;
        logic        e_wen1;
        logic [31:0] e_wd0;
        logic [31:0] e_wd1;
        logic [4:0]  e_rd0;
        logic [4:0]  e_rd1;
        logic [31:0] e_pc0;
        exc_w        e_exc;
        logic [31:0] e_badv;
    } row_t;

    logic         clk;
    logic         arst_n;
    logic         flush;
    logic         in_valid;
    logic         out_allowin;
    logic [31:0]  pc0;
    logic [31:0]  pc1;
    logic [31:0]  inst0;
    logic [31:0]  inst1;
    logic [31:0]  src_a0;
    logic [31:0]  src_b0;
    logic [31:0]  src_a1;
    logic [31:0]  src_b1;
    exc_w         fe_exc;
    logic [31:0]  fe_badv;
    logic         in_allowin;
    logic         out_valid;
    logic [31:0]  out_pc0;
    logic [31:0]  out_pc1;
    logic [4:0]   out_rd0;
    logic [4:0]   out_rd1;
    logic [31:0]  wdata0;
    logic [31:0]  wdata1;
    logic         wen0;
    logic         wen1;
    exc_w         exc;
    logic [31:0]  badv;

    row_t   tbl [max_rows];
    string  row_name [max_rows + 1];
    int     row_errs [max_rows + 1];
    int     n_rows = 0;
    int     cur_row = 0;
    int     err_count = 0;
    int     check_count = 0;
    logic   table_ready = 1'b0;
    integer seed = 32'hb5b7;

    ex_top ex_top_i (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .in_valid(in_valid), .out_allowin(out_allowin),
        .pc0(pc0), .pc1(pc1), .inst0(inst0), .inst1(inst1),
        .src_a0(src_a0), .src_b0(src_b0), .src_a1(src_a1), .src_b1(src_b1),
        .fe_exc(fe_exc), .fe_badv(fe_badv),
        .in_allowin(in_allowin), .out_valid(out_valid),
        .out_pc0(out_pc0), .out_pc1(out_pc1), .out_rd0(out_rd0), .out_rd1(out_rd1),
        .wdata0(wdata0), .wdata1(wdata1), .wen0(wen0), .wen1(wen1),
        .exc(exc), .badv(badv)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] pc_of(input int i);
        return 32'h1c00_0000 + (32'(i) << 4);
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] si12,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, si12, rj, rd};
    endfunction

    // codes 0..5 are the 3R ALU ops, 6 is addi.w, 7 is mul.w
    function automatic logic [31:0] make_word(input int code, input logic [11:0] imm,
                                              input logic [4:0] rk, input logic [4:0] rj,
                                              input logic [4:0] rd);
        logic [16:0] op;
        case (code)
            0:       op = op_add_w;
            1:       op = op_sub_w;
            2:       op = op_slt;
            3:       op = op_and;
            4:       op = op_or;
            5:       op = op_xor;
            default: op = op_mul_w;
        endcase
        return (code == 6) ? enc_2ri12(op_addi_w, imm, rj, rd) : enc_3r(op, rk, rj, rd);
    endfunction

    // ISA result of one lane
    function automatic logic [31:0] ref_result(input int code, input logic [31:0] a,
                                               input logic [31:0] b, input logic [11:0] imm);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        p  = sa * sb;
        case (code)
            0:       return a + b;
            1:       return a - b;
            2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3:       return a & b;
            4:       return a | b;
            5:       return a ^ b;
            6:       return a + {{20{imm[11]}}, imm};
            default: return p[31:0];
        endcase
    endfunction

    task automatic add_pair(input string name, input logic [31:0] w0, input logic [31:0] w1,
                            input logic [31:0] a0, input logic [31:0] b0,
                            input logic [31:0] a1, input logic [31:0] b1,
                            input logic [31:0] wd0, input logic [31:0] wd1);
        row_t t;
        t           = '0;
        t.valid     = 1'b1;
        t.allowin   = 1'b1;
        t.inst0     = w0;
        t.inst1     = w1;
        t.a0        = a0;
        t.b0        = b0;
        t.a1        = a1;
        t.b1        = b1;
        t.pc0       = pc_of(n_rows);
        t.e_valid   = 1'b1;
        t.e_allowin = 1'b1;
        t.e_wen0    = 1'b1;
        t.e_wen1    = 1'b1;
        t.e_wd0     = wd0;
        t.e_wd1     = wd1;
        t.e_rd0     = w0[4:0];
        t.e_rd1     = w1[4:0];
        t.e_pc0     = t.pc0;
        tbl[n_rows]      = t;
        row_name[n_rows] = name;
        n_rows++;
    endtask

    // a pair that must raise an exception and write nothing
    task automatic add_fault(input string name, input logic [31:0] w0, input logic [31:0] w1,
                             input exc_w e_exc, input logic [31:0] e_badv);
        add_pair(name, w0, w1, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0);
        tbl[n_rows-1].e_wen0 = 1'b0;
        tbl[n_rows-1].e_wen1 = 1'b0;
        tbl[n_rows-1].e_exc  = e_exc;
        tbl[n_rows-1].e_badv = e_badv;
    endtask

    task automatic set_front_end(input exc_w e, input logic [31:0] v);
        tbl[n_rows-1].fe_exc  = e;
        tbl[n_rows-1].fe_badv = v;
    endtask

    // outputs keep what the previous row left
    task automatic make_stall();
        tbl[n_rows-1].allowin   = 1'b0;
        tbl[n_rows-1].e_allowin = 1'b0;
        tbl[n_rows-1].e_valid   = tbl[n_rows-2].e_valid;
        tbl[n_rows-1].e_wen0    = tbl[n_rows-2].e_wen0;
        tbl[n_rows-1].e_wen1    = tbl[n_rows-2].e_wen1;
        tbl[n_rows-1].e_wd0     = tbl[n_rows-2].e_wd0;
        tbl[n_rows-1].e_wd1     = tbl[n_rows-2].e_wd1;
        tbl[n_rows-1].e_rd0     = tbl[n_rows-2].e_rd0;
        tbl[n_rows-1].e_rd1     = tbl[n_rows-2].e_rd1;
        tbl[n_rows-1].e_pc0     = tbl[n_rows-2].e_pc0;
        tbl[n_rows-1].e_exc     = tbl[n_rows-2].e_exc;
        tbl[n_rows-1].e_badv    = tbl[n_rows-2].e_badv;
        row_name[n_rows-1]      = {row_name[n_rows-1], ", stalled"};
    endtask

    task automatic make_flush();
        tbl[n_rows-1].flush   = 1'b1;
        tbl[n_rows-1].e_valid = 1'b0;
        tbl[n_rows-1].e_wen0  = 1'b0;
        tbl[n_rows-1].e_wen1  = 1'b0;
        tbl[n_rows-1].e_exc   = '0;
        row_name[n_rows-1]    = {row_name[n_rows-1], ", flushed"};
    endtask

    task automatic add_bubble();
        row_t t;
        t           = '0;
        t.allowin   = 1'b1;
        t.pc0       = pc_of(n_rows);
        t.e_allowin = 1'b1;
        tbl[n_rows]      = t;
        row_name[n_rows] = "bubble";
        n_rows++;
    endtask

    task automatic add_random(input int j);
        integer      r;
        integer      regs;
        int          c0;
        int          c1;
        logic [11:0] imm0;
        logic [11:0] imm1;
        logic [31:0] a0;
        logic [31:0] b0;
        logic [31:0] a1;
        logic [31:0] b1;
        r    = $random(seed);
        regs = $random(seed);
        a0   = $random(seed);
        b0   = $random(seed);
        a1   = $random(seed);
        b1   = $random(seed);
        // first few random rows exercise the multiplier
        c0   = (j < 3) ? 7 : int'(r[2:0]);
        c1   = int'(r[5:3]) % 7;
        imm0 = r[17:6];
        imm1 = r[29:18];
        add_pair($sformatf("random %0d (ops %0d/%0d)", j, c0, c1),
                 make_word(c0, imm0, regs[14:10], regs[9:5], regs[4:0]),
                 make_word(c1, imm1, regs[29:25], regs[24:20], regs[19:15]),
                 a0, b0, a1, b1,
                 ref_result(c0, a0, b0, imm0), ref_result(c1, a1, b1, imm1));
    endtask

    task automatic build_table();
        logic [31:0] held_pc;
        add_pair("add/sub", enc_3r(op_add_w, 5'd2, 5'd1, 5'd3), enc_3r(op_sub_w, 5'd5, 5'd6, 5'd4),
                 32'd5, 32'd7, 32'd3, 32'd5, 32'h0000_000c, 32'hffff_fffe);
        add_pair("slt/and", enc_3r(op_slt, 5'd2, 5'd1, 5'd7), enc_3r(op_and, 5'd9, 5'd10, 5'd8),
                 32'hffff_ffff, 32'd1, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'd1, 32'h00f0_00f0);
        add_pair("or/xor", enc_3r(op_or, 5'd11, 5'd12, 5'd13), enc_3r(op_xor, 5'd14, 5'd15, 5'd16),
                 32'h1234_0000, 32'h0000_5678, 32'hffff_0000, 32'h0ff0_0ff0,
                 32'h1234_5678, 32'hf00f_0ff0);
        add_pair("addi/addi", enc_2ri12(op_addi_w, 12'h800, 5'd1, 5'd17),
                 enc_2ri12(op_addi_w, 12'h7ff, 5'd2, 5'd18),
                 32'h0000_1000, 32'hdead_beef, 32'd1, 32'hdead_beef, 32'h0000_0800, 32'h0000_0800);
        add_pair("slt/addi", enc_3r(op_slt, 5'd3, 5'd4, 5'd19),
                 enc_2ri12(op_addi_w, 12'hfff, 5'd5, 5'd20),
                 32'd5, 32'hffff_fffd, 32'd0, 32'd0, 32'd0, 32'hffff_ffff);
        add_pair("mul/add", enc_3r(op_mul_w, 5'd6, 5'd7, 5'd21),
                 enc_3r(op_add_w, 5'd8, 5'd9, 5'd22),
                 32'hffff_fffd, 32'd7, 32'h7fff_ffff, 32'd1, 32'hffff_ffeb, 32'h8000_0000);
        add_pair("mul/xor", enc_3r(op_mul_w, 5'd1, 5'd2, 5'd23), enc_3r(op_xor, 5'd3, 5'd4, 5'd24),
                 32'h8000_0000, 32'hffff_ffff, 32'haaaa_aaaa, 32'h5555_5555,
                 32'h8000_0000, 32'hffff_ffff);
        add_fault("unknown lane 0", 32'hffff_ffff, enc_3r(op_add_w, 5'd1, 5'd2, 5'd3),
                  {1'b1, ecode_ine}, pc_of(n_rows));
        add_fault("mul.w lane 1", enc_3r(op_add_w, 5'd1, 5'd2, 5'd3),
                  enc_3r(op_mul_w, 5'd4, 5'd5, 5'd6), {1'b1, ecode_ine}, pc_of(n_rows) + 32'd4);
        add_fault("front-end exception", 32'h0000_0000, enc_3r(op_add_w, 5'd1, 5'd2, 5'd3),
                  7'h48, 32'h1c00_0ffc);
        set_front_end(7'h48, 32'h1c00_0ffc);
        add_pair("add/or", enc_3r(op_add_w, 5'd1, 5'd2, 5'd25), enc_3r(op_or, 5'd3, 5'd4, 5'd26),
                 32'd1, 32'd2, 32'd1, 32'd2, 32'd3, 32'd3);
        // the held pair is presented until it is accepted
        held_pc = pc_of(n_rows);
        for (int k = 0; k < 3; k++) begin
            add_pair("sub/xor", enc_3r(op_sub_w, 5'd5, 5'd6, 5'd27),
                     enc_3r(op_xor, 5'd7, 5'd8, 5'd28),
                     32'd10, 32'd3, 32'd6, 32'd3, 32'd7, 32'd5);
            tbl[n_rows-1].pc0   = held_pc;
            tbl[n_rows-1].e_pc0 = held_pc;
            if (k < 2) begin
                make_stall();
            end
        end
        add_bubble();
        add_pair("add/add", enc_3r(op_add_w, 5'd9, 5'd10, 5'd29),
                 enc_3r(op_add_w, 5'd11, 5'd12, 5'd30),
                 32'd100, 32'd200, 32'hffff_ffff, 32'd1, 32'h0000_012c, 32'd0);
        add_pair("and/or", enc_3r(op_and, 5'd1, 5'd2, 5'd3), enc_3r(op_or, 5'd4, 5'd5, 5'd6),
                 32'hff, 32'h0f, 32'hf0, 32'h0f, 32'h0f, 32'hff);
        make_flush();
        add_pair("addi/sub", enc_2ri12(op_addi_w, 12'h001, 5'd7, 5'd8),
                 enc_3r(op_sub_w, 5'd9, 5'd10, 5'd11),
                 32'h7fff_ffff, 32'd0, 32'd0, 32'd1, 32'h8000_0000, 32'hffff_ffff);
        add_pair("xor/and", enc_3r(op_xor, 5'd1, 5'd2, 5'd12), enc_3r(op_and, 5'd3, 5'd4, 5'd13),
                 32'h1, 32'h2, 32'h3, 32'h4, 32'h3, 32'h0);
        make_stall();
        make_flush();
        for (int j = 0; j < 8; j++) begin
            add_random(j);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            row_errs[cur_row]++;
            $display("mismatch %s in %s: got 0x%h, expected 0x%h",
                     name, row_name[cur_row], got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            row_errs[cur_row]++;
            $display("mismatch %s in %s: got 0x%h, expected 0x%h",
                     name, row_name[cur_row], got, exp);
        end
    endtask

    task automatic check_exc(input string name, input exc_w got, input exc_w exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            row_errs[cur_row]++;
            $display("mismatch %s in %s: got 0x%h, expected 0x%h",
                     name, row_name[cur_row], got, exp);
        end
    endtask

    task automatic check_reset();
        cur_row = max_rows;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("wen0", wen0, 1'b0);
        check_bit("wen1", wen1, 1'b0);
        check_bit("exc[6]", exc[6], 1'b0);
    endtask

    task automatic check_row(input int i);
        row_t t;
        t       = tbl[i];
        cur_row = i;
        check_bit("out_valid", out_valid, t.e_valid);
        check_bit("wen0", wen0, t.e_wen0);
        check_bit("wen1", wen1, t.e_wen1);
        check_exc("exc", exc, t.e_exc);
        if (t.e_valid) begin
            check_word("out_pc0", out_pc0, t.e_pc0);
            check_word("out_pc1", out_pc1, t.e_pc0 + 32'd4);
        end
        if (t.e_wen0) begin
            check_word("wdata0", wdata0, t.e_wd0);
            check_word("out_rd0", {27'd0, out_rd0}, {27'd0, t.e_rd0});
        end
        if (t.e_wen1) begin
            check_word("wdata1", wdata1, t.e_wd1);
            check_word("out_rd1", {27'd0, out_rd1}, {27'd0, t.e_rd1});
        end
        if (t.e_exc[6]) begin
            check_word("badv", badv, t.e_badv);
        end
        if (row_errs[i] == 0) begin
            $display("row %0d %s: ok", i, row_name[i]);
        end else begin
            $display("row %0d %s: %0d errors", i, row_name[i], row_errs[i]);
        end
    endtask

    task automatic drive_row(input int i);
        in_valid    <= tbl[i].valid;
        out_allowin <= tbl[i].allowin;
        flush       <= tbl[i].flush;
        inst0       <= tbl[i].inst0;
        inst1       <= tbl[i].inst1;
        src_a0      <= tbl[i].a0;
        src_b0      <= tbl[i].b0;
        src_a1      <= tbl[i].a1;
        src_b1      <= tbl[i].b1;
        pc0         <= tbl[i].pc0;
        pc1         <= tbl[i].pc0 + 32'd4;
        fe_exc      <= tbl[i].fe_exc;
        fe_badv     <= tbl[i].fe_badv;
    endtask

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((n_rows + 20) * 100);
        $display("timeout: run did not finish within %0d clock periods", n_rows + 20);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        out_allowin = 1'b1;
        pc0         = '0;
        pc1         = '0;
        inst0       = '0;
        inst1       = '0;
        src_a0      = '0;
        src_b0      = '0;
        src_a1      = '0;
        src_b1      = '0;
        fe_exc      = '0;
        fe_badv     = '0;
        for (int k = 0; k <= max_rows; k++) begin
            row_errs[k] = 0;
        end
        build_table();
        row_name[max_rows] = "reset";
        table_ready = 1'b1;

        // 8 rising edges with reset held, checked in the middle and after release
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_reset();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_reset();
        if (row_errs[max_rows] == 0) begin
            $display("row - reset: ok");
        end else begin
            $display("row - reset: %0d errors", row_errs[max_rows]);
        end

        // row i is driven while row i-1 is checked
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                drive_row(i);
            end else begin
                in_valid    <= 1'b0;
                out_allowin <= 1'b1;
                flush       <= 1'b0;
            end
            @(negedge clk);
            if (i < n_rows) begin
                cur_row = i;
                check_bit("in_allowin", in_allowin, tbl[i].e_allowin);
            end
            if (i > 0) begin
                check_row(i - 1);
            end
        end

        $display("summary: %0d rows, %0d checks, %0d errors", n_rows + 1, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/ex_pkg.sv
hdl/ex1_decode_alu.sv
hdl/mul_partial.sv
hdl/ex1_ex2_reg.sv
hdl/ex2_result.sv
hdl/ex_top.sv
tb/ex_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ex_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# the run passes only if the pass line shows up in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
